/* project.f */
common/rv_isa_pkg.sv
common/uarch_pkg.sv
common/stage_ifs.sv
decode/inst_decoder.sv
decode/decode_stage.sv
rtl/reg_file.sv
rtl/lane_steer.sv
rtl/decode_issue_top.sv
bench/decode_issue_tb.sv

/* Makefile */
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f project.f --top-module decode_issue_tb
	verilator --lint-only -f project.f --top-module decode_issue_top

sim:
	verilator --binary --timing -f project.f --top-module decode_issue_tb -o decode_issue_sim
	./obj_dir/decode_issue_sim | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/decode_issue_tb.sv */
// ----------------------------------------------------------------------
// Testbench for the decode and issue stage, driven from a table of
// instructions with write-back and lane-ready patterns and checked
// against a reference model
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module decode_issue_tb;
  import rv_isa_pkg::*;
  import uarch_pkg::*;

  localparam int K_ADD  = 0;
  localparam int K_ADDI = 1;
  localparam int K_MUL  = 2;
  localparam int K_LW   = 3;
  localparam int K_SW   = 4;
  localparam int K_JAL  = 5;
  localparam int K_JALR = 6;
  localparam int K_BNE  = 7;
  localparam int K_BAD  = 8;

  typedef struct {
    int          kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        wb_en;
    logic [4:0]  wb_addr;
    logic [31:0] wb_data;
    logic [2:0]  rdy;
    int          hold;
  } row_t;

  logic clk = 1'b0;
  logic rst = 1'b1;
  logic in_val = 1'b0;
  logic in_rdy;
  logic [31:0] in_pc = '0;
  logic [31:0] in_inst = '0;
  logic wb_en = 1'b0;
  logic [4:0] wb_addr = '0;
  logic [31:0] wb_data = '0;
  logic [2:0] lane_rdy = '0;
  logic [2:0] lane_val;
  logic [2:0][31:0] lane_pc;
  logic [2:0][31:0] lane_op1;
  logic [2:0][31:0] lane_op2;
  logic [2:0][4:0] lane_waddr;
  rv_uop_e [2:0] lane_uop;
  logic [2:0][4:0] lane_seq;
  logic illegal;

  row_t rows [$];
  logic [31:0] model_regs [32];
  logic [4:0] seq_model = '0;
  integer seed = 32'h1e52;
  int errors = 0;
  int tests = 0;
  int tests_failed = 0;
  int cycles = 0;
  int limit = 0;

  decode_issue_top decode_issue_top_inst (
    .clk (clk), .rst (rst), .in_val (in_val), .in_rdy (in_rdy), .in_pc (in_pc),
    .in_inst (in_inst), .wb_en (wb_en), .wb_addr (wb_addr), .wb_data (wb_data),
    .lane_rdy (lane_rdy), .lane_val (lane_val), .lane_pc (lane_pc),
    .lane_op1 (lane_op1), .lane_op2 (lane_op2), .lane_waddr (lane_waddr),
    .lane_uop (lane_uop), .lane_seq (lane_seq), .illegal (illegal)
  );

  always #10 clk = ~clk;

  // Run guard
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("Timeout: the run went past %0d cycles without finishing", limit);
      $display("Test failures found");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  function automatic row_t make_row(int kind, logic [4:0] rd, logic [4:0] rs1,
                                    logic [4:0] rs2, logic [31:0] imm, logic we,
                                    logic [4:0] wa, logic [31:0] wd, logic [2:0] rdy,
                                    int hold);
    row_t r;
    r = '{kind, rd, rs1, rs2, imm, we, wa, wd, rdy, hold};
    return r;
  endfunction

  // Builds the instruction word from the TinyRV1 encodings
  function automatic logic [31:0] encode(row_t r);
    logic [31:0] m;
    m = r.imm;
    case (r.kind)
      K_ADD:  return {7'b0000000, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
      K_MUL:  return {7'b0000001, r.rs2, r.rs1, 3'b000, r.rd, 7'b0110011};
      K_ADDI: return {m[11:0], r.rs1, 3'b000, r.rd, 7'b0010011};
      K_LW:   return {m[11:0], r.rs1, 3'b010, r.rd, 7'b0000011};
      K_JALR: return {m[11:0], r.rs1, 3'b000, r.rd, 7'b1100111};
      K_SW:   return {m[11:5], r.rs2, r.rs1, 3'b010, m[4:0], 7'b0100011};
      K_BNE:  return {m[12], m[10:5], r.rs2, r.rs1, 3'b001, m[4:1], m[11], 7'b1100011};
      K_JAL:  return {m[20], m[10:1], m[11], m[19:12], r.rd, 7'b1101111};
      default: return m;
    endcase
  endfunction

  function automatic rv_uop_e kind_uop(int kind);
    case (kind)
      K_MUL:  return uop_mul;
      K_LW:   return uop_lw;
      K_SW:   return uop_sw;
      K_JAL:  return uop_jal;
      K_JALR: return uop_jalr;
      K_BNE:  return uop_bne;
      default: return uop_add;
    endcase
  endfunction

  function automatic logic [31:0] read_reg(logic [4:0] a);
    return (a == 5'd0) ? 32'd0 : model_regs[a];
  endfunction

  function automatic issue_msg_t expect_msg(row_t r, logic [31:0] pc);
    issue_msg_t m;
    m.pc    = pc;
    m.uop   = kind_uop(r.kind);
    m.op1   = (r.kind == K_JAL) ? 32'd0 : read_reg(r.rs1);
    m.op2   = (r.kind inside {K_ADD, K_MUL, K_SW, K_BNE}) ? read_reg(r.rs2) : r.imm;
    m.waddr = (r.kind inside {K_SW, K_BNE}) ? 5'd0 : r.rd;
    m.seq   = seq_model;
    return m;
  endfunction

  function automatic bit lane_accepts(int lane, rv_uop_e u);
    case (lane)
      0: return 1'b1;
      1: return u inside {uop_add, uop_bne, uop_jal, uop_jalr};
      default: return u inside {uop_lw, uop_sw};
    endcase
  endfunction

  function automatic int pick_lane(rv_uop_e u, logic [2:0] rdy);
    for (int i = 0; i < 3; i++) begin
      if (rdy[i] && lane_accepts(i, u)) return i;
    end
    return -1;
  endfunction

  // -1 for no lane, -2 for more than one
  function automatic int lane_of(logic [2:0] v);
    case (v)
      3'b000: return -1;
      3'b001: return 0;
      3'b010: return 1;
      3'b100: return 2;
      default: return -2;
    endcase
  endfunction

  // ----------------------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------------------

  function automatic string msg_text(issue_msg_t m);
    return $sformatf("pc=%h op1=%h op2=%h waddr=%0d uop=%s seq=%0d",
                     m.pc, m.op1, m.op2, m.waddr, m.uop.name(), m.seq);
  endfunction

  task automatic check_msg(string name, issue_msg_t exp, issue_msg_t act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %s actual %s",
               $time, name, msg_text(exp), msg_text(act));
    end
  endtask

  task automatic check_lane(string name, int exp, int act);
    if (exp != act) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
      errors++;
      $display("CHECK FAILED at %0t: %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // ----------------------------------------------------------------------
  // Row driver
  // ----------------------------------------------------------------------

  task automatic run_row(int idx, int pass);
    row_t r;
    issue_msg_t exp;
    issue_msg_t act;
    logic [31:0] pc;
    logic [2:0] rdy_now;
    logic [2:0] stall;
    logic [2:0] prev_stall;
    logic got;
    int lane;
    int waited;
    int err0;
    bit done;
    r = rows[idx];
    pc = 32'h1000 + 32'(pass * 256 + idx * 4);
    err0 = errors;
    in_val = 1'b1;
    in_pc = pc;
    in_inst = encode(r);
    wb_en = r.wb_en;
    wb_addr = r.wb_addr;
    wb_data = r.wb_data;
    rdy_now = r.rdy;
    lane_rdy = r.rdy;
    prev_stall = '0;
    got = 1'b0;
    while (!got) begin
      @(negedge clk);
      got = in_rdy;
      check_flag("illegal", 1'b0, illegal);
      check_lane("lane_val", -1, lane_of(lane_val));
      @(posedge clk);
    end
    // Same-cycle write-back is seen by the read
    if (r.wb_en && r.wb_addr != 5'd0) model_regs[r.wb_addr] = r.wb_data;
    exp = expect_msg(r, pc);
    #1;
    in_val = 1'b0;
    wb_en = 1'b0;
    waited = 0;
    done = 1'b0;
    while (!done) begin
      if (pass == 1) begin
        stall = 3'($random(seed)) & ~prev_stall;
        prev_stall = stall;
        lane_rdy = rdy_now & ~stall;
      end else begin
        lane_rdy = rdy_now;
      end
      @(negedge clk);
      if (r.kind == K_BAD) begin
        check_flag("illegal", 1'b1, illegal);
        check_lane("lane_val", -1, lane_of(lane_val));
        done = 1'b1;
      end else begin
        lane = pick_lane(exp.uop, lane_rdy);
        check_flag("illegal", 1'b0, illegal);
        check_lane("lane_val", lane, lane_of(lane_val));
        if (lane >= 0) begin
          act = '{lane_pc[lane], lane_op1[lane], lane_op2[lane],
                  lane_waddr[lane], lane_uop[lane], lane_seq[lane]};
          check_msg("lane_msg", exp, act);
          seq_model = seq_model + 5'd1;
          done = 1'b1;
        end else begin
          check_flag("in_rdy", 1'b0, in_rdy);
          waited++;
          if (r.hold > 0 && waited >= r.hold) rdy_now = 3'b111;
        end
      end
      @(posedge clk);
      #1;
    end
    tests++;
    if (errors != err0) tests_failed++;
    $display("pass %0d row %2d word %h seq %0d: %s", pass, idx, encode(r), exp.seq,
             (errors == err0) ? "ok" : "FAILED");
  endtask

  task automatic load_table();
    rows.push_back(make_row(K_ADDI, 1, 0, 0, 32'd100, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_ADD, 3, 2, 0, 0, 1, 2, 32'h11, 3'b111, 0));
    rows.push_back(make_row(K_MUL, 4, 2, 1, 0, 1, 1, 32'd7, 3'b111, 0));
    rows.push_back(make_row(K_ADD, 5, 1, 0, 0, 1, 0, 32'hdead, 3'b111, 0));
    rows.push_back(make_row(K_ADDI, 6, 1, 0, 32'd2047, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_ADDI, 7, 2, 0, -32'sd2048, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_LW, 8, 1, 0, -32'sd4, 1, 9, 32'hcafe0001, 3'b111, 0));
    rows.push_back(make_row(K_JALR, 1, 2, 0, -32'sd20, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_JAL, 1, 0, 0, 32'd2048, 0, 0, 0, 3'b111, 0));
    // Word bits 19:15 select x31, which holds a nonzero value here
    rows.push_back(make_row(K_JAL, 9, 0, 0, -32'sd4096, 1, 31, 32'h5a5a5a5a, 3'b111, 0));
    rows.push_back(make_row(K_SW, 0, 1, 2, -32'sd8, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_BNE, 0, 1, 9, -32'sd16, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_BAD, 0, 0, 0, 32'hffffffff, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_ADD, 10, 1, 2, 0, 0, 0, 0, 3'b110, 0));
    rows.push_back(make_row(K_LW, 11, 2, 0, 32'd16, 0, 0, 0, 3'b110, 0));
    rows.push_back(make_row(K_MUL, 12, 1, 2, 0, 1, 12, 32'h80000000, 3'b110, 2));
    rows.push_back(make_row(K_BAD, 0, 0, 0, 32'h40000033, 0, 0, 0, 3'b111, 0));
    rows.push_back(make_row(K_SW, 0, 9, 12, 32'd12, 0, 0, 0, 3'b010, 3));
    rows.push_back(make_row(K_BNE, 0, 12, 1, 32'd64, 0, 0, 0, 3'b100, 1));
    rows.push_back(make_row(K_ADD, 13, 12, 9, 0, 1, 13, 32'd5, 3'b111, 0));
  endtask

  // ----------------------------------------------------------------------
  // Two passes over the table so that seq wraps
  // ----------------------------------------------------------------------

  initial begin
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    load_table();
    limit = rows.size() * 2 * 8 + 50;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    for (int p = 0; p < 2; p++) begin
      for (int i = 0; i < rows.size(); i++) begin
        run_row(i, p);
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d check errors",
             tests, tests - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* rtl/decode_issue_top.sv */
// ----------------------------------------------------------------------
// Decode and issue top level: decode stage, register file and lane
// steering behind plain fetch, write-back and lane ports
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module decode_issue_top (
  input  logic                                                         clk,
  input  logic                                                         rst,
  input  logic                                                         in_val,
  output logic                                                         in_rdy,
  input  logic [rv_isa_pkg::XLEN-1:0]                                  in_pc,
  input  logic [rv_isa_pkg::XLEN-1:0]                                  in_inst,
  input  logic                                                         wb_en,
  input  logic [rv_isa_pkg::REG_ADDR_BITS-1:0]                         wb_addr,
  input  logic [rv_isa_pkg::XLEN-1:0]                                  wb_data,
  input  logic [uarch_pkg::NUM_LANES-1:0]                              lane_rdy,
  output logic [uarch_pkg::NUM_LANES-1:0]                              lane_val,
  output logic [uarch_pkg::NUM_LANES-1:0][rv_isa_pkg::XLEN-1:0]        lane_pc,
  output logic [uarch_pkg::NUM_LANES-1:0][rv_isa_pkg::XLEN-1:0]        lane_op1,
  output logic [uarch_pkg::NUM_LANES-1:0][rv_isa_pkg::XLEN-1:0]        lane_op2,
  output logic [uarch_pkg::NUM_LANES-1:0][rv_isa_pkg::REG_ADDR_BITS-1:0] lane_waddr,
  output rv_isa_pkg::rv_uop_e [uarch_pkg::NUM_LANES-1:0]               lane_uop,
  output logic [uarch_pkg::NUM_LANES-1:0][uarch_pkg::SEQ_BITS-1:0]     lane_seq,
  output logic                                                         illegal
);
  import rv_isa_pkg::*;
  import uarch_pkg::*;

  logic [REG_ADDR_BITS-1:0] rs1;
  logic [REG_ADDR_BITS-1:0] rs2;
  logic [XLEN-1:0]          rdata1;
  logic [XLEN-1:0]          rdata2;
  logic                     held_val;
  issue_msg_t               held_msg;
  logic                     take;

  fetch_if fetch_bus ();
  lane_if  lanes [NUM_LANES] ();

  assign fetch_bus.val  = in_val;
  assign fetch_bus.pc   = in_pc;
  assign fetch_bus.inst = in_inst;
  assign in_rdy         = fetch_bus.rdy;

  decode_stage decode_stage_inst (
    .clk      (clk),
    .rst      (rst),
    .fetch    (fetch_bus),
    .rs1      (rs1),
    .rs2      (rs2),
    .rdata1   (rdata1),
    .rdata2   (rdata2),
    .take     (take),
    .held_val (held_val),
    .held_msg (held_msg),
    .illegal  (illegal)
  );

  reg_file reg_file_inst (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (rs1),
    .raddr2 (rs2),
    .wen    (wb_en),
    .waddr  (wb_addr),
    .wdata  (wb_data),
    .rdata1 (rdata1),
    .rdata2 (rdata2)
  );

  lane_steer lane_steer_inst (
    .held_val (held_val),
    .held_msg (held_msg),
    .take     (take),
    .lanes    (lanes)
  );

  // ----------------------------------------------------------------------
  // Lane interfaces out to plain ports
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane_ports
    assign lanes[i].rdy  = lane_rdy[i];
    assign lane_val[i]   = lanes[i].val;
    assign lane_pc[i]    = lanes[i].msg.pc;
    assign lane_op1[i]   = lanes[i].msg.op1;
    assign lane_op2[i]   = lanes[i].msg.op2;
    assign lane_waddr[i] = lanes[i].msg.waddr;
    assign lane_uop[i]   = lanes[i].msg.uop;
    assign lane_seq[i]   = lanes[i].msg.seq;
  end

endmodule

/* rtl/lane_steer.sv */
// ----------------------------------------------------------------------
// Lane steering: offers the held instruction to the lowest ready
// lane that accepts its micro-op
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module lane_steer (
  input  logic                  held_val,
  input  uarch_pkg::issue_msg_t held_msg,
  output logic                  take,
  lane_if.src                   lanes [uarch_pkg::NUM_LANES]
);
  import rv_isa_pkg::*;
  import uarch_pkg::*;

  rv_op_vec_t           uop_vec;
  logic [NUM_LANES-1:0] lane_rdy;
  logic [NUM_LANES-1:0] fit;
  logic [NUM_LANES-1:0] sel;
  logic                 found;

  // One-hot set bit for the held micro-op
  assign uop_vec = rv_op_vec_t'(1) << held_msg.uop;

  // ----------------------------------------------------------------------
  // Lanes able to accept this op this cycle
  // ----------------------------------------------------------------------

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_fit
    assign lane_rdy[i] = lanes[i].rdy;
    assign fit[i]      = held_val & lane_rdy[i] & (|(LANE_OPS[i] & uop_vec));
  end

  // Lowest index first
  always_comb begin
    sel   = '0;
    found = 1'b0;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (fit[i] && !found) begin
        sel[i] = 1'b1;
        found  = 1'b1;
      end
    end
  end

  assign take = found;

  // Message goes to every lane, val only to the chosen one
  for (genvar i = 0; i < NUM_LANES; i++) begin : g_drive
    assign lanes[i].val = sel[i];
    assign lanes[i].msg = held_msg;
  end

endmodule

/* rtl/reg_file.sv */
// ----------------------------------------------------------------------
// Register file, 32 x 32 bits, two read ports and one write port
// with the write bypassed to same-cycle reads
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module reg_file (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [rv_isa_pkg::REG_ADDR_BITS-1:0] raddr1,
  input  logic [rv_isa_pkg::REG_ADDR_BITS-1:0] raddr2,
  input  logic                                 wen,
  input  logic [rv_isa_pkg::REG_ADDR_BITS-1:0] waddr,
  input  logic [rv_isa_pkg::XLEN-1:0]          wdata,
  output logic [rv_isa_pkg::XLEN-1:0]          rdata1,
  output logic [rv_isa_pkg::XLEN-1:0]          rdata2
);
  import rv_isa_pkg::*;

  localparam int NUM_REGS = 2 ** REG_ADDR_BITS;

  logic [XLEN-1:0] regs [NUM_REGS];

  // x0 reads 0, a pending write wins over the array
  function automatic logic [XLEN-1:0] read_port(input logic [REG_ADDR_BITS-1:0] addr);
    if (addr == '0) begin
      return '0;
    end
    if (wen && waddr == addr) begin
      return wdata;
    end
    return regs[addr];
  endfunction

  assign rdata1 = read_port(raddr1);
  assign rdata2 = read_port(raddr2);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

endmodule

/* decode/decode_stage.sv */
// ----------------------------------------------------------------------
// Decode stage: decodes the fetched word, selects operands and holds
// one numbered issue message until a lane takes it
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module decode_stage (
  input  logic                                 clk,
  input  logic                                 rst,
  fetch_if.dst                                 fetch,
  output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs1,
  output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs2,
  input  logic [rv_isa_pkg::XLEN-1:0]          rdata1,
  input  logic [rv_isa_pkg::XLEN-1:0]          rdata2,
  input  logic                                 take,
  output logic                                 held_val,
  output uarch_pkg::issue_msg_t                held_msg,
  output logic                                 illegal
);
  import rv_isa_pkg::*;
  import uarch_pkg::*;

  rv_uop_e                  dec_uop;
  logic [REG_ADDR_BITS-1:0] dec_rd;
  logic [XLEN-1:0]          dec_imm;
  logic                     dec_use_imm;
  logic                     dec_legal;

  logic                full;
  logic                bad;
  logic                leave;
  logic                load;
  logic [SEQ_BITS-1:0] seq_cnt;
  logic [SEQ_BITS-1:0] seq_inc;
  logic [SEQ_BITS-1:0] seq_next;
  issue_msg_t          next_msg;
  issue_msg_t          msg_q;

  inst_decoder inst_decoder_inst (
    .inst    (fetch.inst),
    .uop     (dec_uop),
    .rs1     (rs1),
    .rs2     (rs2),
    .rd      (dec_rd),
    .imm     (dec_imm),
    .use_imm (dec_use_imm),
    .legal   (dec_legal)
  );

  // ----------------------------------------------------------------------
  // Handshake and sequence numbering
  // ----------------------------------------------------------------------

  // An illegal word leaves on its own at the next edge
  assign illegal  = full & bad;
  assign held_val = full & ~bad;
  assign leave    = illegal | take;
  assign fetch.rdy = ~full | leave;
  assign load     = fetch.val & fetch.rdy;

  assign seq_inc  = (seq_cnt == SEQ_BITS'(ROB_ENTRIES - 1)) ? '0 : seq_cnt + 1'b1;
  assign seq_next = take ? seq_inc : seq_cnt;

  // Operand rule
  always_comb begin
    next_msg.pc    = fetch.pc;
    next_msg.op1   = (dec_uop == uop_jal) ? '0 : rdata1;
    next_msg.op2   = dec_use_imm ? dec_imm : rdata2;
    next_msg.waddr = (dec_uop == uop_sw || dec_uop == uop_bne) ? '0 : dec_rd;
    next_msg.uop   = dec_uop;
    next_msg.seq   = seq_next;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      full    <= 1'b0;
      bad     <= 1'b0;
      seq_cnt <= '0;
    end else begin
      seq_cnt <= seq_next;
      if (load) begin
        full <= 1'b1;
        bad  <= ~dec_legal;
      end else if (leave) begin
        full <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      msg_q <= next_msg;
    end
  end

  assign held_msg = msg_q;

endmodule

/* decode/inst_decoder.sv */
// ----------------------------------------------------------------------
// TinyRV1 instruction decoder: micro-op, register fields and the
// sign-extended immediate of one word, all combinational
// ----------------------------------------------------------------------

`timescale 1ns/1ns

module inst_decoder (
  input  rv_isa_pkg::rv_inst_t              inst,
  output rv_isa_pkg::rv_uop_e               uop,
  output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs1,
  output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rs2,
  output logic [rv_isa_pkg::REG_ADDR_BITS-1:0] rd,
  output logic [rv_isa_pkg::XLEN-1:0]       imm,
  output logic                              use_imm,
  output logic                              legal
);
  import rv_isa_pkg::*;

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;

  // Register fields sit at the same place in every format
  assign rs1 = inst.r_fmt.rs1;
  assign rs2 = inst.r_fmt.rs2;
  assign rd  = inst.r_fmt.rd;

  // ----------------------------------------------------------------------
  // Immediates per format
  // ----------------------------------------------------------------------

  assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
  assign imm_b = {{20{inst.b_fmt.imm12}}, inst.b_fmt.imm11, inst.b_fmt.imm10_5,
                  inst.b_fmt.imm4_1, 1'b0};
  assign imm_j = {{12{inst.j_fmt.imm20}}, inst.j_fmt.imm19_12, inst.j_fmt.imm11,
                  inst.j_fmt.imm10_1, 1'b0};

  // ----------------------------------------------------------------------
  // Opcode and funct match
  // ----------------------------------------------------------------------

  always_comb begin
    uop     = uop_add;
    imm     = '0;
    use_imm = 1'b0;
    legal   = 1'b0;
    case (inst.r_fmt.opcode)
      OPC_OP: begin
        if (inst.r_fmt.funct3 == F3_ADD && inst.r_fmt.funct7 == F7_ADD) begin
          legal = 1'b1;
        end else if (inst.r_fmt.funct3 == F3_ADD && inst.r_fmt.funct7 == F7_MUL) begin
          uop   = uop_mul;
          legal = 1'b1;
        end
      end
      OPC_OP_IMM: begin
        imm     = imm_i;
        use_imm = 1'b1;
        legal   = (inst.i_fmt.funct3 == F3_ADD);
      end
      OPC_LOAD: begin
        uop     = uop_lw;
        imm     = imm_i;
        use_imm = 1'b1;
        legal   = (inst.i_fmt.funct3 == F3_WORD);
      end
      OPC_STORE: begin
        // Store data goes in op2, offset stays off the lane
        uop   = uop_sw;
        imm   = imm_s;
        legal = (inst.s_fmt.funct3 == F3_WORD);
      end
      OPC_JAL: begin
        uop     = uop_jal;
        imm     = imm_j;
        use_imm = 1'b1;
        legal   = 1'b1;
      end
      OPC_JALR: begin
        uop     = uop_jalr;
        imm     = imm_i;
        use_imm = 1'b1;
        legal   = (inst.i_fmt.funct3 == F3_ADD);
      end
      OPC_BRANCH: begin
        uop   = uop_bne;
        imm   = imm_b;
        legal = (inst.b_fmt.funct3 == F3_BNE);
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

endmodule

/* common/stage_ifs.sv */
// ----------------------------------------------------------------------
// Stream interfaces: fetch into decode, decode out to the lanes
// ----------------------------------------------------------------------

`timescale 1ns/1ns

interface fetch_if;
  import rv_isa_pkg::*;

  logic            val;
  logic            rdy;
  logic [XLEN-1:0] pc;
  logic [XLEN-1:0] inst;

  modport src (
    output val,
    output pc,
    output inst,
    input  rdy
  );

  modport dst (
    input  val,
    input  pc,
    input  inst,
    output rdy
  );
endinterface

interface lane_if;
  import uarch_pkg::*;

  logic       val;
  logic       rdy;
  issue_msg_t msg;

  modport src (
    output val,
    output msg,
    input  rdy
  );

  modport dst (
    input  val,
    input  msg,
    output rdy
  );
endinterface

/* common/uarch_pkg.sv */
// ----------------------------------------------------------------------
// Microarchitecture settings for decode and issue: lanes, lane op
// subsets, reorder buffer sequence numbers and the issue message
// ----------------------------------------------------------------------

package uarch_pkg;

  localparam int NUM_LANES   = 3;
  localparam int ROB_ENTRIES = 32;
  localparam int SEQ_BITS    = 5;

  // ----------------------------------------------------------------------
  // Lane op subsets, index 0 first
  // ----------------------------------------------------------------------

  localparam rv_isa_pkg::rv_op_vec_t LANE_OPS [NUM_LANES] = '{
    rv_isa_pkg::TINYRV1_OPS,
    rv_isa_pkg::OP_ADD_VEC | rv_isa_pkg::OP_BNE_VEC |
      rv_isa_pkg::OP_JAL_VEC | rv_isa_pkg::OP_JALR_VEC,
    rv_isa_pkg::OP_LW_VEC | rv_isa_pkg::OP_SW_VEC
  };

  // Message handed to an execution lane
  typedef struct packed {
    logic [rv_isa_pkg::XLEN-1:0]          pc;
    logic [rv_isa_pkg::XLEN-1:0]          op1;
    logic [rv_isa_pkg::XLEN-1:0]          op2;
    logic [rv_isa_pkg::REG_ADDR_BITS-1:0] waddr;
    rv_isa_pkg::rv_uop_e                  uop;
    logic [SEQ_BITS-1:0]                  seq;
  } issue_msg_t;

endpackage

/* common/rv_isa_pkg.sv */
// ----------------------------------------------------------------------
// TinyRV1 instruction set definitions: formats, opcodes, the
// instruction union, micro-ops and the micro-op set vector
// ----------------------------------------------------------------------

package rv_isa_pkg;

  localparam int XLEN          = 32;
  localparam int REG_ADDR_BITS = 5;
  localparam int NUM_UOPS      = 7;

  // Major opcodes of the subset
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [6:0] F7_ADD  = 7'b0000000;
  localparam logic [6:0] F7_MUL  = 7'b0000001;

  // ----------------------------------------------------------------------
  // Instruction formats
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [6:0]               funct7;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [2:0]               funct3;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [6:0]               opcode;
  } rv_r_fmt_t;

  typedef struct packed {
    logic [11:0]              imm;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [2:0]               funct3;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [6:0]               opcode;
  } rv_i_fmt_t;

  typedef struct packed {
    logic [6:0]               imm_hi;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [2:0]               funct3;
    logic [4:0]               imm_lo;
    logic [6:0]               opcode;
  } rv_s_fmt_t;

  typedef struct packed {
    logic                     imm12;
    logic [5:0]               imm10_5;
    logic [REG_ADDR_BITS-1:0] rs2;
    logic [REG_ADDR_BITS-1:0] rs1;
    logic [2:0]               funct3;
    logic [3:0]               imm4_1;
    logic                     imm11;
    logic [6:0]               opcode;
  } rv_b_fmt_t;

  typedef struct packed {
    logic                     imm20;
    logic [9:0]               imm10_1;
    logic                     imm11;
    logic [7:0]               imm19_12;
    logic [REG_ADDR_BITS-1:0] rd;
    logic [6:0]               opcode;
  } rv_j_fmt_t;

  // One word, five views
  typedef union packed {
    rv_r_fmt_t r_fmt;
    rv_i_fmt_t i_fmt;
    rv_s_fmt_t s_fmt;
    rv_b_fmt_t b_fmt;
    rv_j_fmt_t j_fmt;
  } rv_inst_t;

  // add and addi share uop_add
  typedef enum logic [3:0] {
    uop_add,
    uop_mul,
    uop_lw,
    uop_sw,
    uop_jal,
    uop_jalr,
    uop_bne
  } rv_uop_e;

  // Bit n set means micro-op with value n is in the set
  typedef logic [NUM_UOPS-1:0] rv_op_vec_t;

  localparam rv_op_vec_t OP_ADD_VEC  = rv_op_vec_t'(1) << uop_add;
  localparam rv_op_vec_t OP_MUL_VEC  = rv_op_vec_t'(1) << uop_mul;
  localparam rv_op_vec_t OP_LW_VEC   = rv_op_vec_t'(1) << uop_lw;
  localparam rv_op_vec_t OP_SW_VEC   = rv_op_vec_t'(1) << uop_sw;
  localparam rv_op_vec_t OP_JAL_VEC  = rv_op_vec_t'(1) << uop_jal;
  localparam rv_op_vec_t OP_JALR_VEC = rv_op_vec_t'(1) << uop_jalr;
  localparam rv_op_vec_t OP_BNE_VEC  = rv_op_vec_t'(1) << uop_bne;

  localparam rv_op_vec_t TINYRV1_OPS = OP_ADD_VEC | OP_MUL_VEC | OP_LW_VEC | OP_SW_VEC |
                                       OP_JAL_VEC | OP_JALR_VEC | OP_BNE_VEC;

endpackage
